// ==== hw/soc_pkg.sv ====
/* SoC shared definitions: PI1 bus types, op codes, address map and
   device descriptor constants. */
`default_nettype none

package soc_pkg;

	typedef logic [31:0] arch_data_t;
	typedef logic [29:0] arch_addr_t; // Word address.
	typedef logic [3:0] arch_sel_t;
	typedef logic [1:0] pi1_op_t;

	localparam pi1_op_t PI1_OP_NONE = 2'b00;
	localparam pi1_op_t PI1_OP_WRITE = 2'b01;
	localparam pi1_op_t PI1_OP_READ = 2'b10; // 2'b11 is taken as no operation.

	// Word base of each device window.
	localparam arch_addr_t DEVTBL_BASE = 30'd0;
	localparam arch_addr_t GPIO_BASE = 30'd1024;

	localparam arch_data_t DEV_MAPSZ = 32'd4096; // Window size in bytes.

	localparam arch_data_t DEVID_DEVTBL = 32'd1;
	localparam arch_data_t DEVID_GPIO = 32'd2;
	localparam arch_data_t DEV_COUNT = 32'd2;

	localparam int GPIO_COUNT = 8;

endpackage

`default_nettype wire

// ==== hw/pi1_if.sv ====
/* PI1 device link: one registered request from the router and the
   device's same-cycle read data. */
`default_nettype none
`timescale 1ns/1ps

interface pi1_if import soc_pkg::*; ();

	pi1_op_t op;
	arch_addr_t addr; // Offset inside the device window.
	arch_data_t wdata;
	arch_sel_t sel;
	arch_data_t rdata;

	modport router (
		output op, addr, wdata, sel,
		input rdata
	);

	modport device (
		input op, addr, wdata, sel,
		output rdata
	);

endinterface

`default_nettype wire

// ==== hw/rst_sequencer.sv ====
/* Reset sequencer: power-on and warm reset countdown plus a power-off
   latch that holds the system in reset until the board reset. */
`default_nettype none
`timescale 1ns/1ps

module rst_sequencer #(
	parameter int RST_CNTR_BITSZ = 16
) (
	input wire clk100mhz,
	input wire rst_p,
	input wire [1:0] swrst_i,
	output logic sys_rst_o
);

	logic [RST_CNTR_BITSZ-1:0] cntr_q;
	logic pwr_off_q;
	logic warm_rst;
	logic pwr_off;

	// Both bits set would be a cold reset, not supported here.
	assign warm_rst = (swrst_i == 2'b10);
	assign pwr_off = (swrst_i == 2'b01);

	always_ff @(posedge clk100mhz) begin
		if (rst_p || warm_rst)
			cntr_q <= '1;
		else if (cntr_q != '0)
			cntr_q <= cntr_q - 1'b1;
	end

	always_ff @(posedge clk100mhz) begin
		if (rst_p)
			pwr_off_q <= 1'b0;
		else if (pwr_off)
			pwr_off_q <= 1'b1; // Held until the board reset.
	end

	assign sys_rst_o = (cntr_q != '0) || pwr_off_q;

	a_pwr_off_holds: assert property (@(posedge clk100mhz) disable iff (rst_p)
		pwr_off_q |=> (pwr_off_q && sys_rst_o));

endmodule

`default_nettype wire

// ==== hw/activity_led.sv ====
/* Activity LED: one-cycle blink per bus request, then a hold-off while
   the counter runs down. */
`default_nettype none
`timescale 1ns/1ps

module activity_led #(
	parameter int ACTIVITY_CNTR_BITSZ = 7
) (
	input wire clk100mhz,
	input wire sys_rst_i,
	input wire trigger_i,
	output logic activity_o
);

	logic [ACTIVITY_CNTR_BITSZ-1:0] cntr_q;

	always_ff @(posedge clk100mhz) begin
		if (sys_rst_i) begin
			activity_o <= 1'b0;
			cntr_q <= '0;
		end else if (cntr_q != '0) begin
			activity_o <= 1'b0;
			cntr_q <= cntr_q - 1'b1; // Triggers are ignored meanwhile.
		end else if (trigger_i) begin
			activity_o <= 1'b1;
			cntr_q <= '1;
		end
	end

endmodule

`default_nettype wire

// ==== hw/dev_table.sv ====
/* Device table: read-only descriptors of the mapped devices and the
   software reset register. */
`default_nettype none
`timescale 1ns/1ps

module dev_table import soc_pkg::*; (
	input wire clk100mhz,
	input wire sys_rst_i,
	pi1_if.device bus_i,
	output logic [1:0] swrst_o
);

	logic [1:0] swrst_q;
	logic rst_wr;

	assign rst_wr = (bus_i.op == PI1_OP_WRITE) && (bus_i.addr == 30'd1) && bus_i.sel[0];

	always_ff @(posedge clk100mhz) begin
		if (sys_rst_i)
			swrst_q <= 2'b00; // Any reset it caused also ends the request.
		else if (rst_wr)
			swrst_q <= bus_i.wdata[1:0];
	end

	always_comb begin
		case (bus_i.addr)
		30'd0: bus_i.rdata = DEV_COUNT;
		30'd1: bus_i.rdata = {30'b0, swrst_q};
		30'd2: bus_i.rdata = DEVID_DEVTBL;
		30'd3: bus_i.rdata = DEV_MAPSZ;
		30'd4: bus_i.rdata = DEVID_GPIO;
		30'd5: bus_i.rdata = DEV_MAPSZ;
		default: bus_i.rdata = '0;
		endcase
	end

	assign swrst_o = swrst_q;

endmodule

`default_nettype wire

// ==== hw/gpio_port.sv ====
/* GPIO port: two-stage input synchronizer and an output register,
   both reachable over the bus. */
`default_nettype none
`timescale 1ns/1ps

module gpio_port import soc_pkg::*; #(
	parameter int IOCOUNT = GPIO_COUNT
) (
	input wire clk100mhz,
	input wire sys_rst_i,
	pi1_if.device bus_i,
	input wire [IOCOUNT-1:0] gp_i,
	output logic [IOCOUNT-1:1] gp_o
);

	logic [IOCOUNT-1:0] sync1_q;
	logic [IOCOUNT-1:0] sync2_q;
	logic [IOCOUNT-1:1] out_q; // Bit 0 is reserved.
	logic out_wr;

	always_ff @(posedge clk100mhz) begin
		sync1_q <= gp_i;
		sync2_q <= sync1_q;
	end

	assign out_wr = (bus_i.op == PI1_OP_WRITE) && (bus_i.addr == 30'd1) && bus_i.sel[0];

	always_ff @(posedge clk100mhz) begin
		if (sys_rst_i)
			out_q <= '0;
		else if (out_wr)
			out_q <= bus_i.wdata[IOCOUNT-1:1];
	end

	always_comb begin
		case (bus_i.addr)
		30'd0: bus_i.rdata = arch_data_t'(sync2_q);
		30'd1: bus_i.rdata = arch_data_t'({out_q, 1'b0});
		default: bus_i.rdata = '0;
		endcase
	end

	assign gp_o = out_q;

endmodule

`default_nettype wire

// ==== hw/pi1_router.sv ====
/* PI1 router. Takes one master request at a time, decodes the address map
   and returns the selected device's read data; unmapped words read zero. */
`default_nettype none
`timescale 1ns/1ps

module pi1_router import soc_pkg::*; (
	input wire clk100mhz,
	input wire sys_rst_i,
	input wire pi1_op_t pi1_op_i,
	input wire arch_addr_t pi1_addr_i,
	input wire arch_data_t pi1_data_i,
	input wire arch_sel_t pi1_sel_i,
	output arch_data_t pi1_data_o,
	output logic pi1_rdy_o,
	output logic accept_o,
	pi1_if.router devtbl_o,
	pi1_if.router gpio_o
);

	localparam arch_addr_t MAP_WORDS = arch_addr_t'(DEV_MAPSZ >> 2);

	typedef enum logic [1:0] {RT_RESET, RT_IDLE, RT_BUSY} rt_state_t;

	rt_state_t state_q;
	pi1_op_t req_op_q;
	arch_addr_t req_addr_q;
	arch_data_t req_wdata_q;
	arch_sel_t req_sel_q;
	logic hit_devtbl_q;
	logic hit_gpio_q;
	arch_data_t rdata_q;
	arch_addr_t off_devtbl;
	arch_addr_t off_gpio;
	logic hit_devtbl;
	logic hit_gpio;
	logic op_valid;

	assign op_valid = (pi1_op_i == PI1_OP_WRITE) || (pi1_op_i == PI1_OP_READ);
	assign accept_o = pi1_rdy_o && op_valid;

	// Below-base addresses wrap to large offsets and miss.
	assign off_devtbl = pi1_addr_i - DEVTBL_BASE;
	assign off_gpio = pi1_addr_i - GPIO_BASE;
	assign hit_devtbl = off_devtbl < MAP_WORDS;
	assign hit_gpio = off_gpio < MAP_WORDS;

	always_ff @(posedge clk100mhz) begin
		if (sys_rst_i) begin
			state_q <= RT_RESET;
		end else if (state_q == RT_IDLE) begin
			if (accept_o)
				state_q <= RT_BUSY;
		end else begin
			state_q <= RT_IDLE; // Access lasts exactly one cycle.
		end
	end

	always_ff @(posedge clk100mhz) begin
		if (accept_o) begin
			req_op_q <= pi1_op_i;
			req_addr_q <= hit_gpio ? off_gpio : off_devtbl;
			req_wdata_q <= pi1_data_i;
			req_sel_q <= pi1_sel_i;
			hit_devtbl_q <= hit_devtbl;
			hit_gpio_q <= hit_gpio;
		end
		if (state_q == RT_BUSY && req_op_q == PI1_OP_READ)
			rdata_q <= hit_devtbl_q ? devtbl_o.rdata : (hit_gpio_q ? gpio_o.rdata : '0);
	end

	assign devtbl_o.op = (state_q == RT_BUSY && hit_devtbl_q) ? req_op_q : PI1_OP_NONE;
	assign devtbl_o.addr = req_addr_q;
	assign devtbl_o.wdata = req_wdata_q;
	assign devtbl_o.sel = req_sel_q;

	assign gpio_o.op = (state_q == RT_BUSY && hit_gpio_q) ? req_op_q : PI1_OP_NONE;
	assign gpio_o.addr = req_addr_q;
	assign gpio_o.wdata = req_wdata_q;
	assign gpio_o.sel = req_sel_q;

	assign pi1_rdy_o = (state_q == RT_IDLE) && !sys_rst_i; // No requests taken in reset.
	assign pi1_data_o = rdata_q;

	// Master never waits more than one cycle once the system is out of reset.
	a_rdy_one_cycle: assert property (@(posedge clk100mhz) disable iff (sys_rst_i)
		!pi1_rdy_o |=> pi1_rdy_o);

endmodule

`default_nettype wire

// ==== hw/soc_top.sv ====
/* Board-level top: reset sequencer, PI1 router with device table and GPIO,
   and the activity LED, with the master bus on plain ports. */
`default_nettype none
`timescale 1ns/1ps

module soc_top import soc_pkg::*; #(
	parameter int RST_CNTR_BITSZ = 16,
	parameter int ACTIVITY_CNTR_BITSZ = 7,
	localparam int IOCOUNT = GPIO_COUNT
) (
	input wire clk100mhz,
	input wire rst_p,
	input wire pi1_op_t pi1_op_i,
	input wire arch_addr_t pi1_addr_i,
	input wire arch_data_t pi1_data_i,
	input wire arch_sel_t pi1_sel_i,
	output arch_data_t pi1_data_o,
	output logic pi1_rdy_o,
	input wire [IOCOUNT-1:0] gp_i,
	output logic [IOCOUNT-1:1] gp_o,
	output logic activity_o,
	output logic sys_rst_o
);

	logic [1:0] swrst;
	logic accept;

	pi1_if if_devtbl ();
	pi1_if if_gpio ();

	rst_sequencer #(
		.RST_CNTR_BITSZ(RST_CNTR_BITSZ)
	) u_rst_seq (
		.clk100mhz(clk100mhz),
		.rst_p(rst_p),
		.swrst_i(swrst),
		.sys_rst_o(sys_rst_o)
	);

	pi1_router u_router (
		.clk100mhz(clk100mhz),
		.sys_rst_i(sys_rst_o),
		.pi1_op_i(pi1_op_i),
		.pi1_addr_i(pi1_addr_i),
		.pi1_data_i(pi1_data_i),
		.pi1_sel_i(pi1_sel_i),
		.pi1_data_o(pi1_data_o),
		.pi1_rdy_o(pi1_rdy_o),
		.accept_o(accept),
		.devtbl_o(if_devtbl.router),
		.gpio_o(if_gpio.router)
	);

	dev_table u_devtbl (
		.clk100mhz(clk100mhz),
		.sys_rst_i(sys_rst_o),
		.bus_i(if_devtbl.device),
		.swrst_o(swrst)
	);

	gpio_port #(
		.IOCOUNT(IOCOUNT)
	) u_gpio (
		.clk100mhz(clk100mhz),
		.sys_rst_i(sys_rst_o),
		.bus_i(if_gpio.device),
		.gp_i(gp_i),
		.gp_o(gp_o)
	);

	activity_led #(
		.ACTIVITY_CNTR_BITSZ(ACTIVITY_CNTR_BITSZ)
	) u_led (
		.clk100mhz(clk100mhz),
		.sys_rst_i(sys_rst_o),
		.trigger_i(accept),
		.activity_o(activity_o)
	);

endmodule

`default_nettype wire

// ==== testbench/tb_soc_top.sv ====
/* Testbench for soc_top. Drives the PI1 master port through reset, device table,
   GPIO, unmapped, activity LED, warm reset and power-off scenarios. */
`default_nettype none
`timescale 1ns/1ps

module tb_soc_top import soc_pkg::*; ();

	localparam int MAX_CYCLES = 2000;
	localparam int RDY_LIMIT = 300;
	localparam int unsigned SEED = 32'hf0f6f241;

	logic clk100mhz = 1'b0;
	logic rst_p;
	pi1_op_t pi1_op_i;
	arch_addr_t pi1_addr_i;
	arch_data_t pi1_data_i;
	arch_sel_t pi1_sel_i;
	arch_data_t pi1_data_o;
	logic pi1_rdy_o;
	logic [GPIO_COUNT-1:0] gp_i;
	logic [GPIO_COUNT-1:1] gp_o;
	logic activity_o;
	logic sys_rst_o;

	logic [GPIO_COUNT-1:0] model_in = '0; // Expected GPIO input value.
	logic [GPIO_COUNT-1:1] model_out = '0; // Expected GPIO output register.
	int cycles = 0;
	int blinks = 0;
	int errors = 0;
	int tests = 0;
	int failed_tests = 0;

	soc_top #(
		.RST_CNTR_BITSZ(6),
		.ACTIVITY_CNTR_BITSZ(4)
	) uut (
		.clk100mhz(clk100mhz),
		.rst_p(rst_p),
		.pi1_op_i(pi1_op_i),
		.pi1_addr_i(pi1_addr_i),
		.pi1_data_i(pi1_data_i),
		.pi1_sel_i(pi1_sel_i),
		.pi1_data_o(pi1_data_o),
		.pi1_rdy_o(pi1_rdy_o),
		.gp_i(gp_i),
		.gp_o(gp_o),
		.activity_o(activity_o),
		.sys_rst_o(sys_rst_o)
	);

	always #5 clk100mhz = ~clk100mhz;

	always @(posedge clk100mhz) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: run did not end within %0d cycles", MAX_CYCLES);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	always @(negedge clk100mhz) begin
		if (activity_o === 1'b1)
			blinks <= blinks + 1; // One count per LED blink cycle.
	end

	// Expected read data from the address map and the GPIO model.
	function automatic arch_data_t ref_read(input arch_addr_t addr,
			input logic [GPIO_COUNT-1:0] in_val, input logic [GPIO_COUNT-1:1] out_val);
		arch_data_t result;
		result = 32'd0;
		if (addr < 30'd1024) begin
			case (addr)
			30'd0: result = 32'd2;
			30'd2: result = 32'd1;
			30'd3, 30'd5: result = 32'd4096;
			30'd4: result = 32'd2;
			default: result = 32'd0; // Reset register is cleared by the reset it causes.
			endcase
		end else if (addr == 30'd1024) begin
			result = arch_data_t'(in_val);
		end else if (addr == 30'd1025) begin
			result = arch_data_t'({out_val, 1'b0});
		end
		return result;
	endfunction

	task automatic check_data(input string name, input arch_data_t exp, input arch_data_t act);
		if (act !== exp) begin
			$display("[FAIL] %s: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("[FAIL] %s: expected %b, actual %b", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_gpio(input string name, input logic [GPIO_COUNT-1:1] exp,
			input logic [GPIO_COUNT-1:1] act);
		if (act !== exp) begin
			$display("[FAIL] %s: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic finish_test(input string name, input int err_before);
		tests++;
		if (errors == err_before) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, errors - err_before);
			failed_tests++;
		end
	endtask

	task automatic apply_reset();
		@(posedge clk100mhz);
		rst_p <= 1'b1;
		repeat (8) @(posedge clk100mhz);
		rst_p <= 1'b0;
	endtask

	task automatic wait_sys_rst(input logic level, input int limit, output int waited);
		waited = 0;
		@(negedge clk100mhz);
		while (sys_rst_o !== level && waited <= limit) begin
			waited++;
			@(negedge clk100mhz);
		end
		if (sys_rst_o !== level) begin
			$display("sys_rst_o did not go to %b within %0d cycles", level, limit);
			errors++;
		end
	endtask

	task automatic wait_rdy();
		int waited;
		waited = 0;
		@(negedge clk100mhz);
		while (pi1_rdy_o !== 1'b1 && waited < RDY_LIMIT) begin
			waited++;
			@(negedge clk100mhz);
		end
		if (pi1_rdy_o !== 1'b1) begin
			$display("Bus did not raise pi1_rdy_o within %0d cycles", RDY_LIMIT);
			errors++;
		end
	endtask

	task automatic bus_access(input pi1_op_t op, input arch_addr_t addr, input arch_data_t wdata,
			input arch_sel_t sel, output arch_data_t rdata);
		@(posedge clk100mhz);
		pi1_op_i <= op;
		pi1_addr_i <= addr;
		pi1_data_i <= wdata;
		pi1_sel_i <= sel;
		wait_rdy();
		@(posedge clk100mhz); // Request accepted on this edge.
		pi1_op_i <= PI1_OP_NONE;
		wait_rdy();
		rdata = pi1_data_o;
	endtask

	task automatic do_read(input arch_addr_t addr, input string name);
		arch_data_t rdata;
		bus_access(PI1_OP_READ, addr, '0, 4'hf, rdata);
		check_data(name, ref_read(addr, model_in, model_out), rdata);
	endtask

	task automatic do_write(input arch_addr_t addr, input arch_data_t wdata, input arch_sel_t sel);
		arch_data_t unused;
		bus_access(PI1_OP_WRITE, addr, wdata, sel, unused);
		if (addr == 30'd1025 && sel[0])
			model_out = wdata[GPIO_COUNT-1:1];
	endtask

	initial begin
		arch_data_t wd;
		int err0;
		int n;
		int act0;
		wd = $urandom(SEED); // Seeds the generator for the whole run.
		rst_p <= 1'b1;
		pi1_op_i <= PI1_OP_NONE;
		pi1_addr_i <= '0;
		pi1_data_i <= '0;
		pi1_sel_i <= '0;
		gp_i <= '0;

		err0 = errors;
		apply_reset();
		wait_sys_rst(1'b0, 200, n);
		if (n < 62) begin
			$display("sys_rst_o fell after %0d cycles, expected at least 62", n);
			errors++;
		end
		@(negedge clk100mhz);
		check_bit("rdy after reset", 1'b1, pi1_rdy_o);
		check_gpio("gp_o after reset", '0, gp_o);
		check_bit("activity after reset", 1'b0, activity_o);
		finish_test("reset_release", err0);

		err0 = errors;
		for (int i = 0; i < 8; i++)
			do_read(arch_addr_t'(i), $sformatf("device table word %0d", i));
		finish_test("device_table", err0);

		err0 = errors;
		wd = $urandom();
		model_in = wd[GPIO_COUNT-1:0];
		@(posedge clk100mhz);
		gp_i <= model_in;
		repeat (4) @(posedge clk100mhz);
		do_read(30'd1024, "gpio input");
		wd = $urandom();
		do_write(30'd1025, wd, arch_sel_t'($urandom()) | 4'h1);
		check_gpio("gp_o after write", wd[GPIO_COUNT-1:1], gp_o);
		do_read(30'd1025, "gpio output readback");
		do_write(30'd1025, ~wd, arch_sel_t'($urandom()) & 4'he);
		check_gpio("gp_o after lane 0 masked write", model_out, gp_o);
		do_read(30'd1025, "gpio output after masked write");
		finish_test("gpio", err0);

		err0 = errors;
		do_read(30'd4096, "unmapped read");
		do_write(30'd4096, $urandom(), 4'hf);
		check_gpio("gp_o after unmapped write", model_out, gp_o);
		repeat (20) @(posedge clk100mhz);
		act0 = blinks;
		do_read(30'd0, "activity trigger read");
		// Accepts come every 3 cycles, so these all fall in the hold-off.
		for (int i = 0; i < 5; i++)
			do_read(30'd2, "activity hold-off read");
		@(posedge clk100mhz);
		check_data("activity blink count", 32'd1, arch_data_t'(blinks - act0));
		finish_test("unmapped_activity", err0);

		err0 = errors;
		do_write(30'd1025, 32'hff, 4'h1);
		check_gpio("gp_o before warm reset", model_out, gp_o);
		do_write(30'd1, 32'd2, 4'h1);
		wait_sys_rst(1'b1, 4, n);
		check_bit("rdy low in warm reset", 1'b0, pi1_rdy_o);
		model_out = '0;
		wait_sys_rst(1'b0, 100, n);
		check_gpio("gp_o after warm reset", model_out, gp_o);
		do_read(30'd1, "reset register after warm reset");
		finish_test("warm_reset", err0);

		err0 = errors;
		do_write(30'd1, 32'd1, 4'h1);
		wait_sys_rst(1'b1, 4, n);
		repeat (200) @(posedge clk100mhz);
		@(negedge clk100mhz);
		check_bit("sys_rst held by power-off", 1'b1, sys_rst_o);
		check_bit("rdy held low by power-off", 1'b0, pi1_rdy_o);
		apply_reset();
		wait_sys_rst(1'b0, 100, n);
		model_out = '0;
		do_read(30'd0, "device count after board reset");
		finish_test("power_off", err0);

		$display("Tests run: %0d, tests failed: %0d, check errors: %0d",
			tests, failed_tests, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
hw/soc_pkg.sv
hw/pi1_if.sv
hw/rst_sequencer.sv
hw/activity_led.sv
hw/dev_table.sv
hw/gpio_port.sv
hw/pi1_router.sv
hw/soc_top.sv
testbench/tb_soc_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and decide the result from the log.
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_soc_top \
	-f flist.f --Mdir obj_dir -o tb_soc_top \
	&& ./obj_dir/tb_soc_top > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^TESTBENCH PASSED$" sim.log 2>/dev/null \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
